// ==== hdl/QuplsPkg.sv ====
// Qupls decode package
// Shared types, opcodes and helper functions

package QuplsPkg;

// ====================
// Basic types
// ====================

// Architectural register number, wide enough for the banked stack pointers
typedef logic [8:0] aregno_t;
// Privilege mode, where 3 is machine mode
typedef logic [1:0] operating_mode_t;
// Raw 32-bit instruction word
typedef logic [31:0] instruction_t;
// Immediate value as seen by the execute stages
typedef logic [63:0] value_t;

// A raw word together with its zero-extended register fields
typedef struct packed {
	instruction_t ins;
	aregno_t aRt;
	aregno_t aRa;
	aregno_t aRb;
	aregno_t aRc;
} ex_instruction_t;

// ====================
// Opcodes
// ====================

typedef enum logic [6:0] {
	OP_R2    = 7'd2,
	OP_SHIFT = 7'd3,
	OP_ADD   = 7'd4,
	OP_AND   = 7'd8,
	OP_OR    = 7'd9,
	OP_LDO   = 7'd67,
	OP_STB   = 7'd80,
	OP_STW   = 7'd81,
	OP_STT   = 7'd82,
	OP_STO   = 7'd83,
	OP_STH   = 7'd84,
	OP_STX   = 7'd85,
	OP_REGC  = 7'd120,
	OP_PFXC  = 7'd121,
	OP_NOP   = 7'd127
} opcode_t;

// Register 31 is the stack pointer and is banked by mode and level
localparam aregno_t REG_SP = 9'd31;
localparam aregno_t SP_MBASE = 9'd32;
localparam aregno_t SP_UBASE = 9'd40;
localparam operating_mode_t OM_MACHINE = 2'd3;

// ====================
// Functions
// ====================

// The opcode field of a raw word
function automatic opcode_t fnOpcode(input instruction_t ins);
	return opcode_t'(ins[6:0]);
endfunction

// True for all six store opcodes
function automatic logic fnIsStore(input instruction_t ins);
	case (fnOpcode(ins))
	OP_STB, OP_STW, OP_STT, OP_STO, OP_STH, OP_STX:
		return 1'b1;
	default:
		return 1'b0;
	endcase
endfunction

// The Ci flag turns the Rc field into a small immediate, except where
// the Rc field already has another use
function automatic logic fnImmc(input instruction_t ins);
	opcode_t op;
	op = fnOpcode(ins);
	return ins[31] && !fnIsStore(ins) && op != OP_SHIFT && op != OP_R2;
endfunction

// Machine mode picks a stack pointer by interrupt level, lower modes by mode
function automatic aregno_t fnMapSp(input aregno_t r, input operating_mode_t om,
	input logic [2:0] ipl);
	if (r != REG_SP)
		return r;
	if (om == OM_MACHINE)
		return SP_MBASE | {6'd0, ipl};
	return SP_UBASE | {7'd0, om};
endfunction

endpackage

// ==== hdl/Qupls_ins_extract.sv ====
// Fetch group input register
// Latches the group and splits out the register fields

module Qupls_ins_extract import QuplsPkg::*; #(
	parameter int NGRP = 2
) (
	input logic clk,
	input logic reset,
	input logic inValid,
	input instruction_t ins0,
	input instruction_t ins1,
	input operating_mode_t om,
	input logic [2:0] ipl,
	output logic grpValid,
	output ex_instruction_t [NGRP-1:0] instr,
	output operating_mode_t omR,
	output logic [2:0] iplR
);

// Words for each slot of the group before field extraction
instruction_t grpWord [0:NGRP-1];

// Each field is six bits wide and zero-extends into the register number
function automatic ex_instruction_t fnExtract(input instruction_t ins);
	ex_instruction_t ex;
	ex.ins = ins;
	ex.aRt = {3'd0, ins[12:7]};
	ex.aRa = {3'd0, ins[18:13]};
	ex.aRb = {3'd0, ins[24:19]};
	ex.aRc = {3'd0, ins[30:25]};
	return ex;
endfunction

// Only two words arrive, so any further slots hold a NOP
always_comb begin
	for (int n = 0; n < NGRP; n = n + 1) begin
		if (n == 0)
			grpWord[n] = ins0;
		else if (n == 1)
			grpWord[n] = ins1;
		else
			grpWord[n] = {25'd0, OP_NOP};
	end
end

// The valid flag moves every edge, the data only with a new group
always_ff @(posedge clk) begin
	if (reset) begin
		grpValid <= 1'b0;
		omR <= '0;
		iplR <= '0;
		instr <= '0;
	end
	else begin
		grpValid <= inValid;
		if (inValid) begin
			omR <= om;
			iplR <= ipl;
			for (int n = 0; n < NGRP; n = n + 1)
				instr[n] <= fnExtract(grpWord[n]);
		end
	end
end

endmodule

// ==== hdl/Qupls_decode_Rabt.sv ====
// Ra, Rb and Rt decoder

module Qupls_decode_Rabt import QuplsPkg::*; #(
	parameter int NGRP = 2
) (
	input operating_mode_t om,
	input logic [2:0] ipl,
	input ex_instruction_t [NGRP-1:0] instr,
	output aregno_t Ra,
	output aregno_t Rb,
	output aregno_t Rt,
	output logic Raz,
	output logic Rbz
);

// Set when the Rc field of word 0 is read as an immediate
logic immcW0;
// Set when word 0 is a store, which has no target register
logic storeW0;

assign immcW0 = fnImmc(instr[0].ins);
assign storeW0 = fnIsStore(instr[0].ins);

always_comb begin
	// Ra always comes straight from its field, with stack pointer banking
	Ra = fnMapSp(instr[0].aRa, om, ipl);

	// An immediate C operand leaves no register for Rb to read
	if (immcW0)
		Rb = 9'd0;
	else
		Rb = fnMapSp(instr[0].aRb, om, ipl);

	// Stores use the Rt field as a source, so the target is dropped here
	// and picked up by the Rc decoder instead
	if (storeW0)
		Rt = 9'd0;
	else
		Rt = instr[0].aRt;

	// The zero flags look at the register after banking
	Raz = ~|Ra;
	Rbz = ~|Rb;
end

endmodule

// ==== hdl/Qupls_decode_Rc.sv ====
// Rc and Rcc decoder

module Qupls_decode_Rc import QuplsPkg::*; #(
	parameter int NGRP = 2
) (
	input operating_mode_t om,
	input logic [2:0] ipl,
	input ex_instruction_t [NGRP-1:0] instr,
	input logic has_immc,
	output aregno_t Rc,
	output logic Rcz,
	output logic [2:0] Rcc
);

// Rc before the postfix override and the stack pointer banking
aregno_t rcBase;

always_comb begin
	rcBase = 9'd0;
	Rcc = 3'd0;

	// A PFXC postfix supplies the C operand, so no register is read
	if (has_immc)
		rcBase = 9'd0;
	else begin
		case (fnOpcode(instr[0].ins))
		// Store data sits in the Rt field
		OP_STB, OP_STW, OP_STT, OP_STO, OP_STH, OP_STX:
			rcBase = instr[0].aRt;
		// Shift and R2 ignore the Ci flag and always read Rc
		OP_SHIFT, OP_R2:
			rcBase = instr[0].aRc;
		default:
			if (fnImmc(instr[0].ins))
				rcBase = 9'd0;
			else
				rcBase = instr[0].aRc;
		endcase
	end

	// A REGC postfix wins over every rule above
	if (fnOpcode(instr[1].ins) == OP_REGC) begin
		rcBase = instr[1].aRt;
		Rcc = instr[1].ins[15:13];
	end

	// Register 31 goes to the banked stack pointer
	Rc = fnMapSp(rcBase, om, ipl);
	Rcz = ~|Rc;
end

endmodule

// ==== hdl/Qupls_decode_immc.sv ====
// C immediate decoder
// Builds the 64-bit C operand from a postfix or the Rc field

module Qupls_decode_immc import QuplsPkg::*; #(
	parameter int NGRP = 2
) (
	input ex_instruction_t [NGRP-1:0] instr,
	output logic has_immc,
	output value_t immc,
	output logic usesPostfix
);

// Opcode of the word that follows the primary instruction
opcode_t opW1;
// The PFXC payload fills bits 31 to 7 of the postfix word
logic [24:0] pfxImm;
// The inline immediate reuses the six Rc field bits
logic [5:0] rcImm;

assign opW1 = fnOpcode(instr[1].ins);
assign pfxImm = instr[1].ins[31:7];
assign rcImm = instr[0].ins[30:25];

always_comb begin
	has_immc = 1'b0;
	immc = '0;

	// A PFXC postfix carries the whole immediate
	if (opW1 == OP_PFXC) begin
		has_immc = 1'b1;
		immc = {{39{pfxImm[24]}}, pfxImm};
	end
	// Otherwise a Ci-flagged word 0 gives a small signed constant
	else if (fnImmc(instr[0].ins)) begin
		immc = {{58{rcImm[5]}}, rcImm};
	end
end

// Either postfix kind consumes word 1, which the next stage must skip
assign usesPostfix = (opW1 == OP_REGC) || (opW1 == OP_PFXC);

endmodule

// ==== hdl/Qupls_decode_out.sv ====
// Decoded bundle output register

module Qupls_decode_out import QuplsPkg::*; (
	input logic clk,
	input logic reset,
	input logic grpValid,
	input aregno_t Ra,
	input aregno_t Rb,
	input aregno_t Rc,
	input aregno_t Rt,
	input logic Raz,
	input logic Rbz,
	input logic Rcz,
	input logic [2:0] Rcc,
	input value_t immc,
	input logic has_immc,
	input logic usesPostfix,
	output logic outValid,
	output aregno_t RaO,
	output aregno_t RbO,
	output aregno_t RcO,
	output aregno_t RtO,
	output logic RazO,
	output logic RbzO,
	output logic RczO,
	output logic [2:0] RccO,
	output value_t immcO,
	output logic hasImmcO,
	output logic usesPostfixO
);

// The valid pulse follows every edge, the bundle holds between groups
always_ff @(posedge clk) begin
	if (reset) begin
		outValid <= 1'b0;
		RaO <= '0;
		RbO <= '0;
		RcO <= '0;
		RtO <= '0;
		RazO <= 1'b0;
		RbzO <= 1'b0;
		RczO <= 1'b0;
		RccO <= '0;
		immcO <= '0;
		hasImmcO <= 1'b0;
		usesPostfixO <= 1'b0;
	end
	else begin
		outValid <= grpValid;
		if (grpValid) begin
			RaO <= Ra;
			RbO <= Rb;
			RcO <= Rc;
			RtO <= Rt;
			RazO <= Raz;
			RbzO <= Rbz;
			RczO <= Rcz;
			RccO <= Rcc;
			immcO <= immc;
			hasImmcO <= has_immc;
			usesPostfixO <= usesPostfix;
		end
	end
end

endmodule

// ==== hdl/Qupls_decoder.sv ====
// Register field decode stage
// Two cycles from the group strobe to the decoded bundle

module Qupls_decoder import QuplsPkg::*; #(
	// Words per fetch group, at least two since word 1 may be a postfix
	parameter int NGRP = 2
) (
	input logic clk,
	input logic reset,
	input logic inValid,
	input instruction_t ins0,
	input instruction_t ins1,
	input operating_mode_t om,
	input logic [2:0] ipl,
	output logic outValid,
	output aregno_t Ra,
	output aregno_t Rb,
	output aregno_t Rc,
	output aregno_t Rt,
	output logic Raz,
	output logic Rbz,
	output logic Rcz,
	output logic [2:0] Rcc,
	output value_t immc,
	output logic hasImmc,
	output logic usesPostfix
);

// ====================
// First stage
// ====================

ex_instruction_t [NGRP-1:0] instr;
logic grpValid;
operating_mode_t omR;
logic [2:0] iplR;

Qupls_ins_extract #(.NGRP(NGRP)) insExtract (
	.clk(clk),
	.reset(reset),
	.inValid(inValid),
	.ins0(ins0),
	.ins1(ins1),
	.om(om),
	.ipl(ipl),
	.grpValid(grpValid),
	.instr(instr),
	.omR(omR),
	.iplR(iplR)
);

// ====================
// Field decode
// ====================

// Decoder outputs before the output register
aregno_t decRa, decRb, decRc, decRt;
logic decRaz, decRbz, decRcz;
logic [2:0] decRcc;
value_t decImmc;
logic decHasImmc;
logic decUsesPostfix;

Qupls_decode_Rabt #(.NGRP(NGRP)) decodeRabt (
	.om(omR),
	.ipl(iplR),
	.instr(instr),
	.Ra(decRa),
	.Rb(decRb),
	.Rt(decRt),
	.Raz(decRaz),
	.Rbz(decRbz)
);

// The immediate decoder tells the Rc decoder about a PFXC postfix
Qupls_decode_immc #(.NGRP(NGRP)) decodeImmc (
	.instr(instr),
	.has_immc(decHasImmc),
	.immc(decImmc),
	.usesPostfix(decUsesPostfix)
);

Qupls_decode_Rc #(.NGRP(NGRP)) decodeRc (
	.om(omR),
	.ipl(iplR),
	.instr(instr),
	.has_immc(decHasImmc),
	.Rc(decRc),
	.Rcz(decRcz),
	.Rcc(decRcc)
);

// ====================
// Output stage
// ====================

Qupls_decode_out decodeOut (
	.clk(clk),
	.reset(reset),
	.grpValid(grpValid),
	.Ra(decRa),
	.Rb(decRb),
	.Rc(decRc),
	.Rt(decRt),
	.Raz(decRaz),
	.Rbz(decRbz),
	.Rcz(decRcz),
	.Rcc(decRcc),
	.immc(decImmc),
	.has_immc(decHasImmc),
	.usesPostfix(decUsesPostfix),
	.outValid(outValid),
	.RaO(Ra),
	.RbO(Rb),
	.RcO(Rc),
	.RtO(Rt),
	.RazO(Raz),
	.RbzO(Rbz),
	.RczO(Rcz),
	.RccO(Rcc),
	.immcO(immc),
	.hasImmcO(hasImmc),
	.usesPostfixO(usesPostfix)
);

endmodule

// ==== testbench/Qupls_decoder_tb.sv ====
// Register field decode stage testbench

module Qupls_decoder_tb import QuplsPkg::*; ();
timeunit 1ns;
timeprecision 100ps;

localparam int RESET_CYCLES = 8;
localparam int NUM_RANDOM = 150;
// Groups sent by the directed tests ahead of the random one
localparam int DIRECTED_GROUPS = 36;
// Groups in all tests, each one taking two cycles at most
localparam int MAX_GROUPS = DIRECTED_GROUPS + NUM_RANDOM;
localparam int WATCHDOG_NS = (RESET_CYCLES + 2 * MAX_GROUPS + 200) * 8;
localparam instruction_t NOPW = {25'd0, OP_NOP};
localparam logic [6:0] STORE_OPS [0:5] = '{OP_STB, OP_STW, OP_STT, OP_STO, OP_STH, OP_STX};

// Expected decoded bundle for one group
typedef struct packed {
	aregno_t ra;
	aregno_t rb;
	aregno_t rc;
	aregno_t rt;
	logic raz;
	logic rbz;
	logic rcz;
	logic [2:0] rcc;
	value_t immc;
	logic hasImmc;
	logic usesPostfix;
} bundle_t;

logic clk, reset, inValid;
instruction_t ins0, ins1;
operating_mode_t om;
logic [2:0] ipl;
logic outValid, Raz, Rbz, Rcz, hasImmc, usesPostfix;
aregno_t Ra, Rb, Rc, Rt;
logic [2:0] Rcc;
value_t immc;

bundle_t expQ [$];
bundle_t expB;
// High for the clock edge where expB holds the bundle on the outputs
logic chk;
// Strobe history, bit 1 is the strobe from two edges back
logic [1:0] validHist;
logic [31:0] lcgState;
int errCount, testStartErrs, testsPassed, testsFailed;

Qupls_decoder #(.NGRP(2)) Qupls_decoder_i (.*);

always #4 clk = ~clk;

// ====================
// Reference model
// ====================

function automatic logic [31:0] nextRand();
	lcgState = lcgState * 32'd1664525 + 32'd1013904223;
	return lcgState;
endfunction

function automatic logic isStoreOp(input logic [6:0] op);
	return op inside {OP_STB, OP_STW, OP_STT, OP_STO, OP_STH, OP_STX};
endfunction

// Register 31 picks one of the banked stack pointers
function automatic aregno_t bankSp(input aregno_t r, input operating_mode_t m,
	input logic [2:0] lvl);
	if (r != 9'd31)
		return r;
	return (m == 2'd3) ? 9'd32 + {6'd0, lvl} : 9'd40 + {7'd0, m};
endfunction

function automatic instruction_t makeWord(input logic ci, input logic [5:0] rc,
	input logic [5:0] rb, input logic [5:0] ra, input logic [5:0] rt, input logic [6:0] op);
	return {ci, rc, rb, ra, rt, op};
endfunction

// One byte of random picks a register field, a quarter of them the stack pointer
function automatic logic [5:0] pickReg(input logic [7:0] v);
	return (v[7:6] == 2'b00) ? 6'd31 : v[5:0];
endfunction

function automatic bundle_t predict(input instruction_t w0, input instruction_t w1,
	input operating_mode_t m, input logic [2:0] lvl);
	bundle_t b;
	logic st, sh, imm, pfx, regc;
	aregno_t rcRaw;
	st = isStoreOp(w0[6:0]);
	sh = (w0[6:0] == OP_SHIFT) || (w0[6:0] == OP_R2);
	// The Ci flag only means an immediate where Rc has no other use
	imm = w0[31] && !st && !sh;
	pfx = (w1[6:0] == OP_PFXC);
	regc = (w1[6:0] == OP_REGC);
	b.ra = bankSp({3'd0, w0[18:13]}, m, lvl);
	b.rb = imm ? 9'd0 : bankSp({3'd0, w0[24:19]}, m, lvl);
	b.rt = st ? 9'd0 : {3'd0, w0[12:7]};
	if (pfx || imm)
		rcRaw = 9'd0;
	else if (st)
		rcRaw = {3'd0, w0[12:7]};
	else
		rcRaw = {3'd0, w0[30:25]};
	// REGC beats every other Rc rule
	if (regc)
		rcRaw = {3'd0, w1[12:7]};
	b.rcc = regc ? w1[15:13] : 3'd0;
	b.rc = bankSp(rcRaw, m, lvl);
	b.raz = (b.ra == 9'd0);
	b.rbz = (b.rb == 9'd0);
	b.rcz = (b.rc == 9'd0);
	if (pfx)
		b.immc = 64'($signed(w1[31:7]));
	else if (imm)
		b.immc = 64'($signed(w0[30:25]));
	else
		b.immc = 64'd0;
	b.hasImmc = pfx;
	b.usesPostfix = pfx || regc;
	return b;
endfunction

// ====================
// Checking
// ====================

function automatic void reportMismatch(input string what, input value_t got, input value_t want);
	errCount++;
	$display("FAILED at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, want);
endfunction

always @(posedge clk) begin
	if (reset)
		validHist <= 2'b00;
	else
		validHist <= {validHist[0], inValid};
end

// Outputs settle after the rising edge, so the expected bundle is picked here
always @(negedge clk) begin
	chk = 1'b0;
	if (!reset && outValid) begin
		if (expQ.size() == 0) begin
			errCount++;
			$display("Output valid at %0t ns with no group in flight", $time);
		end
		else begin
			expB = expQ.pop_front();
			chk = 1'b1;
		end
	end
end

// Exactly two edges from strobe to outValid, and nothing in between
assert property (@(posedge clk) disable iff (reset) outValid == validHist[1])
	else reportMismatch("outValid", value_t'($sampled(outValid)),
		value_t'($sampled(validHist[1])));
assert property (@(posedge clk) chk |-> Ra == expB.ra)
	else reportMismatch("Ra", value_t'($sampled(Ra)), value_t'(expB.ra));
assert property (@(posedge clk) chk |-> Rb == expB.rb)
	else reportMismatch("Rb", value_t'($sampled(Rb)), value_t'(expB.rb));
assert property (@(posedge clk) chk |-> Rc == expB.rc)
	else reportMismatch("Rc", value_t'($sampled(Rc)), value_t'(expB.rc));
assert property (@(posedge clk) chk |-> Rt == expB.rt)
	else reportMismatch("Rt", value_t'($sampled(Rt)), value_t'(expB.rt));
assert property (@(posedge clk) chk |-> Raz == expB.raz)
	else reportMismatch("Raz", value_t'($sampled(Raz)), value_t'(expB.raz));
assert property (@(posedge clk) chk |-> Rbz == expB.rbz)
	else reportMismatch("Rbz", value_t'($sampled(Rbz)), value_t'(expB.rbz));
assert property (@(posedge clk) chk |-> Rcz == expB.rcz)
	else reportMismatch("Rcz", value_t'($sampled(Rcz)), value_t'(expB.rcz));
assert property (@(posedge clk) chk |-> Rcc == expB.rcc)
	else reportMismatch("Rcc", value_t'($sampled(Rcc)), value_t'(expB.rcc));
assert property (@(posedge clk) chk |-> immc == expB.immc)
	else reportMismatch("immc", $sampled(immc), expB.immc);
assert property (@(posedge clk) chk |-> hasImmc == expB.hasImmc)
	else reportMismatch("hasImmc", value_t'($sampled(hasImmc)), value_t'(expB.hasImmc));
assert property (@(posedge clk) chk |-> usesPostfix == expB.usesPostfix)
	else reportMismatch("usesPostfix", value_t'($sampled(usesPostfix)),
		value_t'(expB.usesPostfix));

// ====================
// Stimulus
// ====================

task automatic sendGroup(input instruction_t w0, input instruction_t w1,
	input operating_mode_t m, input logic [2:0] lvl);
	@(negedge clk);
	inValid = 1'b1;
	ins0 = w0;
	ins1 = w1;
	om = m;
	ipl = lvl;
	expQ.push_back(predict(w0, w1, m, lvl));
endtask

task automatic idleCycle();
	@(negedge clk);
	inValid = 1'b0;
endtask

// Let the pipeline drain so the last bundle is checked, then report the test
task automatic endTest(input string name);
	int errs;
	idleCycle();
	while (expQ.size() != 0)
		@(negedge clk);
	@(negedge clk);
	errs = errCount - testStartErrs;
	testStartErrs = errCount;
	if (errs == 0)
		testsPassed++;
	else
		testsFailed++;
	$display("Test %s finished with %0d errors", name, errs);
endtask

task automatic sendRandomGroup();
	logic [31:0] r, s, t;
	logic [6:0] op0;
	instruction_t w0, w1;
	r = nextRand();
	s = nextRand();
	t = nextRand();
	// Mostly listed opcodes, now and then a raw one
	case (r[3:0])
	4'd0: op0 = OP_R2;
	4'd1: op0 = OP_SHIFT;
	4'd2, 4'd12: op0 = OP_ADD;
	4'd3: op0 = OP_AND;
	4'd4, 4'd13: op0 = OP_OR;
	4'd5: op0 = OP_LDO;
	4'd6, 4'd7, 4'd8, 4'd9, 4'd10, 4'd11: op0 = STORE_OPS[r[26:24] % 3'd6];
	default: op0 = r[14:8];
	endcase
	w0 = makeWord(r[31], pickReg(s[7:0]), pickReg(s[15:8]), pickReg(s[23:16]),
		pickReg(s[31:24]), op0);
	case (r[5:4])
	2'd0: w1 = {t[24:0], OP_PFXC};
	2'd1: w1 = {t[31:13], pickReg(t[7:0]), OP_REGC};
	2'd2: w1 = {t[31:7], OP_ADD};
	default: w1 = NOPW;
	endcase
	sendGroup(w0, w1, r[7:6], r[18:16]);
	if (r[30:29] == 2'b00)
		idleCycle();
endtask

initial begin
	clk = 1'b0;
	reset = 1'b1;
	inValid = 1'b0;
	ins0 = NOPW;
	ins1 = NOPW;
	om = 2'd0;
	ipl = 3'd0;
	chk = 1'b0;
	lcgState = 32'h371e;
	errCount = 0;
	testStartErrs = 0;
	testsPassed = 0;
	testsFailed = 0;
	repeat (RESET_CYCLES) @(posedge clk);
	@(negedge clk);
	reset = 1'b0;

	// Quiet after reset, then back to back groups and groups with gaps
	repeat (4) idleCycle();
	for (int k = 0; k < 3; k++)
		sendGroup(makeWord(1'b0, 6'd3, 6'd2, 6'd1, 6'(k + 4), OP_ADD), NOPW, 2'd0, 3'd0);
	idleCycle();
	idleCycle();
	sendGroup(makeWord(1'b0, 6'd8, 6'd9, 6'd10, 6'd11, OP_AND), NOPW, 2'd0, 3'd0);
	sendGroup(makeWord(1'b0, 6'd12, 6'd13, 6'd14, 6'd15, OP_OR), NOPW, 2'd0, 3'd0);
	endTest("latency");

	// Stores read Rt, shift and R2 ignore Ci, other Ci opcodes drop Rc
	for (int k = 0; k < 6; k++)
		sendGroup(makeWord(k[0], 6'd5, 6'd6, 6'd7, 6'd9, STORE_OPS[k]), NOPW, 2'd0, 3'd0);
	sendGroup(makeWord(1'b1, 6'd12, 6'd1, 6'd2, 6'd3, OP_SHIFT), NOPW, 2'd0, 3'd0);
	sendGroup(makeWord(1'b1, 6'd13, 6'd1, 6'd2, 6'd3, OP_R2), NOPW, 2'd0, 3'd0);
	sendGroup(makeWord(1'b1, 6'd14, 6'd1, 6'd2, 6'd3, OP_ADD), NOPW, 2'd0, 3'd0);
	sendGroup(makeWord(1'b0, 6'd0, 6'd0, 6'd0, 6'd3, OP_AND), NOPW, 2'd0, 3'd0);
	sendGroup(makeWord(1'b0, 6'd17, 6'd1, 6'd2, 6'd3, OP_OR), NOPW, 2'd0, 3'd0);
	endTest("rcSelect");

	// REGC replaces Rc and supplies Rcc, even over an inline immediate
	sendGroup(makeWord(1'b1, 6'd3, 6'd1, 6'd2, 6'd4, OP_ADD),
		makeWord(1'b0, 6'd0, 6'd0, 6'd5, 6'd22, OP_REGC), 2'd0, 3'd0);
	sendGroup(makeWord(1'b0, 6'd3, 6'd1, 6'd2, 6'd4, OP_STO),
		makeWord(1'b0, 6'd0, 6'd0, 6'd7, 6'd31, OP_REGC), 2'd1, 3'd2);
	sendGroup(makeWord(1'b0, 6'd9, 6'd1, 6'd2, 6'd4, OP_SHIFT),
		makeWord(1'b0, 6'd0, 6'd0, 6'd2, 6'd0, OP_REGC), 2'd0, 3'd0);
	endTest("regcPostfix");

	// Every mode with a spread of interrupt levels
	for (int m = 0; m < 4; m++)
		for (int l = 0; l < 8; l += 3)
			sendGroup(makeWord(1'b0, 6'd31, 6'd31, 6'd31, 6'd31, OP_OR), NOPW,
				operating_mode_t'(m), 3'(l));
	endTest("spBanking");

	// Inline immediates of both signs, PFXC payloads of both signs
	sendGroup(makeWord(1'b1, 6'h3f, 6'd1, 6'd2, 6'd3, OP_ADD), NOPW, 2'd0, 3'd0);
	sendGroup(makeWord(1'b1, 6'h1f, 6'd1, 6'd2, 6'd3, OP_AND), NOPW, 2'd0, 3'd0);
	sendGroup(makeWord(1'b0, 6'd4, 6'd1, 6'd2, 6'd3, OP_LDO), {25'h1000000, OP_PFXC},
		2'd0, 3'd0);
	sendGroup(makeWord(1'b0, 6'd4, 6'd1, 6'd2, 6'd3, OP_ADD), {25'h0abcde, OP_PFXC},
		2'd0, 3'd0);
	sendGroup(makeWord(1'b0, 6'd4, 6'd1, 6'd2, 6'd8, OP_STB), {25'h1fffff0, OP_PFXC},
		2'd0, 3'd0);
	endTest("immediates");

	for (int g = 0; g < NUM_RANDOM; g++)
		sendRandomGroup();
	endTest("random");

	$display("Tests passed: %0d, tests failed: %0d, check errors: %0d",
		testsPassed, testsFailed, errCount);
	if (testsFailed == 0 && errCount == 0)
		$display("STATUS: PASS");
	else
		$display("STATUS: FAIL");
	$finish;
end

// Ends a run that stops making progress
initial begin
	#(WATCHDOG_NS);
	$display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
	$display("STATUS: FAIL");
	$finish;
end

endmodule

// ==== Qupls_decoder.f ====
hdl/QuplsPkg.sv
hdl/Qupls_ins_extract.sv
hdl/Qupls_decode_Rabt.sv
hdl/Qupls_decode_Rc.sv
hdl/Qupls_decode_immc.sv
hdl/Qupls_decode_out.sv
hdl/Qupls_decoder.sv
testbench/Qupls_decoder_tb.sv

// ==== Makefile ====
# Verilator build and run for the Qupls decode stage

TOP = Qupls_decoder_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -Mdir obj_dir -f Qupls_decoder.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "STATUS: FAIL" sim.log; then echo "Simulation reported failure"; exit 1; fi
	@grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
